// File: tzfeDisplay.f
+incdir+include
design/tzfePkg.sv
design/tileBoard.sv
design/scoreTable.sv
design/digitPanel.sv
design/frameCompose.sv
design/tzfeDisplay.sv
verif/tzfeClockGen.sv
verif/tzfeDisplayTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tzfeDisplayTb
FILELIST ?= tzfeDisplay.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
FAIL_MSG ?= Simulation failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# a crash that prints nothing of its own still counts as a failure
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tzfeDisplayTb.sv
`include "tzfe_settings.svh"
`timescale 1ns/1ps

module tzfeDisplayTb;

	localparam int STIM_DELAY = 5;
	localparam int PERIOD_NS = 100;
	localparam int STROBES = 12;

	// sweep x0..x1 by dx on each row y0..y1 by dy
	typedef struct packed {
		int x0, x1, dx, y0, y1, dy;
	} regionT;

	localparam regionT TABLE_AREA = '{526, 597, 3, 198, 432, 4};
	localparam regionT BOARD_AREA = '{0, 475, 7, 0, 475, 9};
	localparam regionT SCORE_AREA = '{470, 610, 1, 105, 135, 1};
	localparam regionT BLANK_AREA = '{0, 620, 11, 0, 470, 11};

	// five rows of four pixels, top left pixel in the msb
	localparam logic [19:0] FONT [10] = '{20'hF999F, 20'h26227, 20'hF1F8F, 20'hF171F,
		20'h99F11, 20'hF8F1F, 20'hF8F9F, 20'hF1244, 20'hF9F9F, 20'hF9F1F};

	logic vga_clk;
	logic arstN;
	tzfePkg::pixelPosT pos;
	tzfePkg::boardT board;
	logic [`TZFE_SCORE_W-1:0] score;
	logic gameEnd;
	tzfePkg::rgbT rgb;

	int modelTable [`TZFE_TABLE_DEPTH];
	logic [31:0] lfsrState = 32'h7b14_6697;
	tzfePkg::rgbT curExp;
	logic curValid;
	int checkCount, errorCount, testCount, testChecks, testErrors;

	tzfeClockGen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(3)) clockGen_i (
		.vga_clk (vga_clk),
		.arstN (arstN)
	);

	tzfeDisplay dut_i (
		.vga_clk (vga_clk),
		.arstN (arstN),
		.pos (pos),
		.board (board),
		.score (score),
		.gameEnd (gameEnd),
		.rgb (rgb)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] bits;
		logic feedback;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			bits = {bits[30:0], feedback};
		end
		return bits;
	endfunction

	function automatic bit inSpan(input int v, input int start, input int len);
		return v >= start && v < start + len;
	endfunction

	function automatic int areaPixels(input regionT a);
		return ((a.x1 - a.x0) / a.dx + 1) * ((a.y1 - a.y0) / a.dy + 1);
	endfunction

	function automatic tzfePkg::rgbT expectedRgb(input tzfePkg::pixelPosT p);
		int x;
		int y;
		int top;
		int left;
		int value;
		int fontBit;
		logic hit;
		logic ink;
		logic [3:0] code;
		tzfePkg::rgbT colour;
		x = int'(p.x);
		y = int'(p.y);
		hit = 1'b0;
		ink = 1'b0;
		code = 4'd0;
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				if (inSpan(x, `TZFE_BOARD_ORIGIN + c * `TZFE_TILE_PITCH, `TZFE_TILE_SIZE) &&
						inSpan(y, `TZFE_BOARD_ORIGIN + r * `TZFE_TILE_PITCH, `TZFE_TILE_SIZE)) begin
					hit = 1'b1;
					code = board[c * 4 + r];
				end
			end
		end
		// score row, then one row per table entry
		for (int r = 0; r <= `TZFE_TABLE_DEPTH; r++) begin
			top = (r == 0) ? `TZFE_SCORE_Y : `TZFE_TABLE_Y + (r - 1) * `TZFE_ROW_PITCH;
			for (int c = 0; c < 4; c++) begin
				left = `TZFE_DIGIT_X + c * `TZFE_DIGIT_PITCH;
				if (inSpan(x, left, `TZFE_DIGIT_W) && inSpan(y, top, `TZFE_DIGIT_H)) begin
					if (r == 0) begin
						value = int'(score) % 10000;
					end else begin
						value = modelTable[r - 1] % 10000;
					end
					fontBit = 19 - 4 * ((y - top) / `TZFE_FONT_SCALE) - (x - left) / `TZFE_FONT_SCALE;
					ink = FONT[(value / (10 ** (3 - c))) % 10][fontBit];
				end
			end
		end
		if (!p.active) begin
			colour = '0;
		end else if (hit) begin
			if (code == 4'd0) begin
				colour = tzfePkg::rgbT'(`TZFE_COL_EMPTY);
			end else begin
				colour = '{4'hF, 4'hF - code, 4'h0};
			end
		end else if (x >= `TZFE_PANEL_X) begin
			colour = ink ? tzfePkg::rgbT'(`TZFE_COL_INK) : tzfePkg::rgbT'(`TZFE_COL_PANEL);
		end else begin
			colour = tzfePkg::rgbT'(`TZFE_COL_GAP);
		end
		return colour;
	endfunction

	// new score goes above the first entry it beats
	function automatic void insertScore(input int s);
		int place;
		if (s <= modelTable[`TZFE_TABLE_DEPTH - 1]) begin
			return;
		end
		foreach (modelTable[i]) begin
			if (modelTable[i] == s) begin
				return;
			end
		end
		place = 0;
		while (modelTable[place] >= s) begin
			place++;
		end
		for (int i = `TZFE_TABLE_DEPTH - 1; i > place; i--) begin
			modelTable[i] = modelTable[i - 1];
		end
		modelTable[place] = s;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
		checkCount++;
		if (got !== want) begin
			errorCount++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
		end
	endtask

	task automatic drivePixel(input int x, input int y, input logic active);
		@(posedge vga_clk);
		#STIM_DELAY;
		pos.x = `TZFE_COORD_W'(x);
		pos.y = `TZFE_COORD_W'(y);
		pos.active = active;
		curExp = expectedRgb(pos);
	endtask

	task automatic sweep(input regionT a, input bit alternate);
		logic active;
		active = 1'b1;
		for (int y = a.y0; y <= a.y1; y += a.dy) begin
			for (int x = a.x0; x <= a.x1; x += a.dx) begin
				drivePixel(x, y, active);
				active = alternate ? ~active : 1'b1;
			end
		end
	endtask

	task automatic loadInputs(input tzfePkg::boardT newBoard, input int newScore);
		@(posedge vga_clk);
		#STIM_DELAY;
		board = newBoard;
		score = `TZFE_SCORE_W'(newScore);
		pos.active = 1'b0;
		curExp = expectedRgb(pos);
	endtask

	task automatic endGame(input int s);
		loadInputs(board, s);
		gameEnd = 1'b1;
		// table takes the score at the coming edge
		insertScore(s);
		@(posedge vga_clk);
		#STIM_DELAY;
		gameEnd = 1'b0;
	endtask

	task automatic finishTest(input string name);
		// drain the two pipeline stages
		repeat (4) @(negedge vga_clk);
		testCount++;
		$display("test %s: %0d checks, %0d errors", name, checkCount - testChecks,
			errorCount - testErrors);
		testChecks = checkCount;
		testErrors = errorCount;
	endtask

	// rgb is stable at the falling edge, two rising edges after its pixel
	initial begin : compareProc
		tzfePkg::rgbT expA;
		tzfePkg::rgbT expB;
		tzfePkg::pixelPosT posA;
		tzfePkg::pixelPosT posB;
		logic validA;
		logic validB;
		validA = 1'b0;
		validB = 1'b0;
		forever begin
			@(negedge vga_clk);
			if (validB && arstN) begin
				checkValue($sformatf("rgb at (%0d,%0d)", posB.x, posB.y), 32'(rgb), 32'(expB));
			end
			expB = expA;
			posB = posA;
			validB = validA && arstN;
			expA = curExp;
			posA = pos;
			validA = curValid && arstN;
		end
	end

	initial begin : watchdog
		longint cycles;
		cycles = areaPixels(TABLE_AREA) * (STROBES + 1) + areaPixels(BOARD_AREA) +
			areaPixels(SCORE_AREA) + areaPixels(BLANK_AREA) + 4 * STROBES + 64;
		#(cycles * PERIOD_NS * 2);
		$display("Timeout: tests still running after %0d ns", cycles * PERIOD_NS * 2);
		$display("Simulation failed");
		$finish;
	end

	initial begin : stimulus
		tzfePkg::boardT newBoard;
		int pastScores [$];
		int s;
		pos = '0;
		board = '0;
		score = '0;
		gameEnd = 1'b0;
		curExp = '0;
		curValid = 1'b0;
		{checkCount, errorCount, testCount, testChecks, testErrors} = '0;
		foreach (modelTable[i]) begin
			modelTable[i] = 0;
		end
		wait (arstN === 1'b1);
		checkValue("rgb after reset", 32'(rgb), 32'h0);
		curValid = 1'b1;
		sweep(TABLE_AREA, 1'b0);
		finishTest("reset");

		foreach (newBoard[i]) begin
			newBoard[i] = 4'(randomBits(4));
		end
		loadInputs(newBoard, 0);
		sweep(BOARD_AREA, 1'b0);
		finishTest("tiles");

		loadInputs(newBoard, int'(randomBits(`TZFE_SCORE_W)));
		sweep(SCORE_AREA, 1'b0);
		finishTest("score");

		// every fourth score repeats, every third of a group is small
		for (int i = 0; i < STROBES; i++) begin
			if (i % 4 == 3) begin
				s = pastScores[i - 2];
			end else if (i % 4 == 2) begin
				s = int'(randomBits(6));
			end else begin
				s = int'(randomBits(`TZFE_SCORE_W));
			end
			pastScores.push_back(s);
			endGame(s);
			sweep(TABLE_AREA, 1'b0);
		end
		finishTest("table");

		sweep(BLANK_AREA, 1'b1);
		finishTest("blanking");

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: verif/tzfeClockGen.sv
`timescale 1ns/1ps

module tzfeClockGen #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic vga_clk,
	output logic arstN
);

	initial begin
		vga_clk = 1'b0;
		forever #(PERIOD_NS / 2) vga_clk = ~vga_clk;
	end

	// release just after an edge, like the other inputs
	initial begin
		arstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge vga_clk);
		#5 arstN = 1'b1;
	end

endmodule

// File: design/tzfeDisplay.sv
`include "tzfe_settings.svh"
`timescale 1ns/1ps

module tzfeDisplay (
	input logic vga_clk,
	input logic arstN,
	input tzfePkg::pixelPosT pos,
	input tzfePkg::boardT board,
	input logic [`TZFE_SCORE_W-1:0] score,
	input logic gameEnd,
	output tzfePkg::rgbT rgb
);

	tzfePkg::tilePixelT tile;
	tzfePkg::panelPixelT panel;
	tzfePkg::scoreListT entries;

	// first stage, tile lookup
	tileBoard tileBoardInst (
		.vga_clk (vga_clk),
		.arstN (arstN),
		.pos (pos),
		.board (board),
		.tile (tile)
	);

	scoreTable scoreTableInst (
		.vga_clk (vga_clk),
		.arstN (arstN),
		.gameEnd (gameEnd),
		.score (score),
		.entries (entries)
	);

	// first stage, panel text
	digitPanel digitPanelInst (
		.vga_clk (vga_clk),
		.arstN (arstN),
		.pos (pos),
		.score (score),
		.entries (entries),
		.panel (panel)
	);

	// second stage, colour out
	frameCompose frameComposeInst (
		.vga_clk (vga_clk),
		.arstN (arstN),
		.pos (pos),
		.tile (tile),
		.panel (panel),
		.rgb (rgb)
	);

endmodule

// File: design/frameCompose.sv
`include "tzfe_settings.svh"
`timescale 1ns/1ps

module frameCompose (
	input logic vga_clk,
	input logic arstN,
	input tzfePkg::pixelPosT pos,
	input tzfePkg::tilePixelT tile,
	input tzfePkg::panelPixelT panel,
	output tzfePkg::rgbT rgb
);

	logic activeD;
	tzfePkg::rgbT colour;

	// active lines up with the tile and panel registers
	always_ff @(posedge vga_clk or negedge arstN) begin
		if (!arstN) begin
			activeD <= 1'b0;
		end else begin
			activeD <= pos.active;
		end
	end

	always_comb begin
		if (!activeD) begin
			colour = '0;
		end else if (tile.hit) begin
			if (tile.exponent == 4'd0) begin
				colour = tzfePkg::rgbT'(`TZFE_COL_EMPTY);
			end else begin
				// higher tiles fade from yellow to red
				colour = '{red: 4'hF, green: 4'hF - tile.exponent, blue: 4'h0};
			end
		end else if (panel.ink) begin
			colour = tzfePkg::rgbT'(`TZFE_COL_INK);
		end else if (panel.inPanel) begin
			colour = tzfePkg::rgbT'(`TZFE_COL_PANEL);
		end else begin
			colour = tzfePkg::rgbT'(`TZFE_COL_GAP);
		end
	end

	always_ff @(posedge vga_clk or negedge arstN) begin
		if (!arstN) begin
			rgb <= '0;
		end else begin
			rgb <= colour;
		end
	end

endmodule

// File: design/digitPanel.sv
`include "tzfe_settings.svh"
`timescale 1ns/1ps

module digitPanel (
	input logic vga_clk,
	input logic arstN,
	input tzfePkg::pixelPosT pos,
	input logic [`TZFE_SCORE_W-1:0] score,
	input tzfePkg::scoreListT entries,
	output tzfePkg::panelPixelT panel
);

	localparam int ROWS = `TZFE_TABLE_DEPTH + 1;
	localparam int ROW_W = $clog2(ROWS);
	localparam int ENTRY_W = $clog2(`TZFE_TABLE_DEPTH);
	localparam int GLYPH_W = `TZFE_DIGIT_W / `TZFE_FONT_SCALE;
	localparam int GLYPH_H = `TZFE_DIGIT_H / `TZFE_FONT_SCALE;

	logic rowHit;
	logic colHit;
	logic [ROW_W-1:0] rowIdx;
	logic [1:0] colIdx;
	logic [`TZFE_COORD_W-1:0] xOff;
	logic [`TZFE_COORD_W-1:0] yOff;
	logic [1:0] fx;
	logic [2:0] fy;
	logic [`TZFE_SCORE_W-1:0] value;
	logic [3:0] digit;
	logic [GLYPH_W*GLYPH_H-1:0] glyph;
	tzfePkg::panelPixelT panelNext;

	// 4x5 font, top row in the high nibble, left pixel in the msb
	function automatic logic [GLYPH_W*GLYPH_H-1:0] glyphOf(input logic [3:0] d);
		case (d)
			4'd0: return 20'hF999F;
			4'd1: return 20'h26227;
			4'd2: return 20'hF1F8F;
			4'd3: return 20'hF171F;
			4'd4: return 20'h99F11;
			4'd5: return 20'hF8F1F;
			4'd6: return 20'hF8F9F;
			4'd7: return 20'hF1244;
			4'd8: return 20'hF9F9F;
			4'd9: return 20'hF9F1F;
			default: return '0;
		endcase
	endfunction

	// row 0 is the current score, rows 1 to 8 the table
	always_comb begin
		int top;
		rowHit = 1'b0;
		rowIdx = '0;
		yOff = '0;
		for (int r = 0; r < ROWS; r++) begin
			top = (r == 0) ? `TZFE_SCORE_Y : `TZFE_TABLE_Y + (r - 1) * `TZFE_ROW_PITCH;
			if (int'(pos.y) >= top && int'(pos.y) < top + `TZFE_DIGIT_H) begin
				rowHit = 1'b1;
				rowIdx = ROW_W'(r);
				yOff = pos.y - `TZFE_COORD_W'(top);
			end
		end
	end

	always_comb begin
		int left;
		colHit = 1'b0;
		colIdx = '0;
		xOff = '0;
		for (int c = 0; c < 4; c++) begin
			left = `TZFE_DIGIT_X + c * `TZFE_DIGIT_PITCH;
			if (int'(pos.x) >= left && int'(pos.x) < left + `TZFE_DIGIT_W) begin
				colHit = 1'b1;
				colIdx = 2'(c);
				xOff = pos.x - `TZFE_COORD_W'(left);
			end
		end
	end

	always_comb begin
		int bitIdx;
		value = (rowIdx == '0) ? score : entries[ENTRY_W'(rowIdx - 1'b1)];
		digit = tzfePkg::decimalDigit(value, colIdx);
		glyph = glyphOf(digit);
		// scale screen offset down to font pixels
		fx = 2'(xOff / `TZFE_FONT_SCALE);
		fy = 3'(yOff / `TZFE_FONT_SCALE);
		bitIdx = GLYPH_W * GLYPH_H - 1 - GLYPH_W * int'(fy) - int'(fx);
		panelNext.inPanel = pos.x >= `TZFE_COORD_W'(`TZFE_PANEL_X);
		panelNext.ink = rowHit && colHit && glyph[bitIdx];
	end

	always_ff @(posedge vga_clk or negedge arstN) begin
		if (!arstN) begin
			panel <= '0;
		end else begin
			panel <= panelNext;
		end
	end

	// digits must stay inside the panel
	assert property (@(posedge vga_clk) disable iff (!arstN) panel.ink |-> panel.inPanel);

endmodule

// File: design/scoreTable.sv
`include "tzfe_settings.svh"
`timescale 1ns/1ps

module scoreTable (
	input logic vga_clk,
	input logic arstN,
	input logic gameEnd,
	input logic [`TZFE_SCORE_W-1:0] score,
	output tzfePkg::scoreListT entries
);

	localparam int DEPTH = `TZFE_TABLE_DEPTH;

	logic [DEPTH-1:0] above;
	logic [DEPTH-1:0] prevAbove;
	logic [DEPTH-1:0] match;
	logic doInsert;
	logic ordered;
	tzfePkg::scoreListT shifted;
	tzfePkg::scoreListT nextEntries;

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			above[i] = score > entries[i];
			match[i] = score == entries[i];
		end
		// first slot where the new score wins is where it lands
		prevAbove = {above[DEPTH-2:0], 1'b0};
		shifted = {entries[DEPTH-2:0], score};
		doInsert = gameEnd && above[DEPTH-1] && !(|match);
		for (int i = 0; i < DEPTH; i++) begin
			if (prevAbove[i]) begin
				nextEntries[i] = shifted[i];
			end else if (above[i]) begin
				nextEntries[i] = score;
			end else begin
				nextEntries[i] = entries[i];
			end
		end
	end

	always_ff @(posedge vga_clk or negedge arstN) begin
		if (!arstN) begin
			entries <= '0;
		end else if (doInsert) begin
			entries <= nextEntries;
		end
	end

	always_comb begin
		ordered = 1'b1;
		for (int i = 1; i < DEPTH; i++) begin
			if (entries[i] > entries[i-1]) begin
				ordered = 1'b0;
			end
		end
	end

	// insertions must keep the table sorted best first
	assert property (@(posedge vga_clk) disable iff (!arstN) ordered);

endmodule

// File: design/tileBoard.sv
`include "tzfe_settings.svh"
`timescale 1ns/1ps

module tileBoard (
	input logic vga_clk,
	input logic arstN,
	input tzfePkg::pixelPosT pos,
	input tzfePkg::boardT board,
	output tzfePkg::tilePixelT tile
);

	localparam int CELLS = `TZFE_CELLS_PER_SIDE;
	localparam int IDX_W = $clog2(CELLS);
	localparam int ORIGIN = `TZFE_BOARD_ORIGIN;
	localparam int PITCH = `TZFE_TILE_PITCH;
	localparam int SIZE = `TZFE_TILE_SIZE;

	logic colHit;
	logic rowHit;
	logic [IDX_W-1:0] col;
	logic [IDX_W-1:0] row;
	logic [2*IDX_W-1:0] cellIdx;
	tzfePkg::tilePixelT tileNext;

	// returns {hit, index} for one axis, gaps give no hit
	function automatic logic [IDX_W:0] axisLookup(input logic [`TZFE_COORD_W-1:0] coord);
		logic [IDX_W:0] found;
		int start;
		found = '0;
		for (int i = 0; i < CELLS; i++) begin
			start = ORIGIN + PITCH * i;
			if (int'(coord) >= start && int'(coord) < start + SIZE) begin
				found = {1'b1, IDX_W'(i)};
			end
		end
		return found;
	endfunction

	always_comb begin
		{colHit, col} = axisLookup(pos.x);
		{rowHit, row} = axisLookup(pos.y);
		// column major, matching the game logic's board order
		cellIdx = {col, row};
		tileNext.hit = colHit && rowHit;
		tileNext.exponent = tileNext.hit ? board[cellIdx] : 4'd0;
	end

	always_ff @(posedge vga_clk or negedge arstN) begin
		if (!arstN) begin
			tile <= '0;
		end else begin
			tile <= tileNext;
		end
	end

endmodule

// File: design/tzfePkg.sv
`include "tzfe_settings.svh"

package tzfePkg;

	// one output colour, red in the top nibble
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgbT;

	// position of the pixel being drawn
	typedef struct packed {
		logic [`TZFE_COORD_W-1:0] x;
		logic [`TZFE_COORD_W-1:0] y;
		logic active;
	} pixelPosT;

	// exponent codes, cell index is column * 4 + row
	typedef logic [`TZFE_CELLS_PER_SIDE*`TZFE_CELLS_PER_SIDE-1:0][3:0] boardT;

	// entry 0 holds the best score
	typedef logic [`TZFE_TABLE_DEPTH-1:0][`TZFE_SCORE_W-1:0] scoreListT;

	typedef struct packed {
		logic hit;
		logic [3:0] exponent;
	} tilePixelT;

	typedef struct packed {
		logic inPanel;
		logic ink;
	} panelPixelT;

	// place 0 is thousands, place 3 is units
	function automatic logic [3:0] decimalDigit(input logic [`TZFE_SCORE_W-1:0] value,
			input logic [1:0] place);
		logic [13:0] shown;
		logic [3:0] digit;
		shown = 14'(value % 10000);
		case (place)
			2'd0: digit = 4'(shown / 1000);
			2'd1: digit = 4'((shown / 100) % 10);
			2'd2: digit = 4'((shown / 10) % 10);
			default: digit = 4'(shown % 10);
		endcase
		return digit;
	endfunction

endpackage

// File: include/tzfe_settings.svh
`ifndef TZFE_SETTINGS_SVH
`define TZFE_SETTINGS_SVH

// pixel and score widths
`define TZFE_COORD_W 10
`define TZFE_SCORE_W 17

// board and table sizes
`define TZFE_CELLS_PER_SIDE 4
`define TZFE_TABLE_DEPTH 8

// board geometry in screen pixels
`define TZFE_BOARD_ORIGIN 15
`define TZFE_TILE_PITCH 115
`define TZFE_TILE_SIZE 100

// side panel layout
`define TZFE_PANEL_X 480
`define TZFE_DIGIT_X 528
`define TZFE_DIGIT_PITCH 17
`define TZFE_DIGIT_W 16
`define TZFE_DIGIT_H 20
`define TZFE_FONT_SCALE 4
`define TZFE_SCORE_Y 110
`define TZFE_TABLE_Y 200
`define TZFE_ROW_PITCH 30

// colours as 12-bit rgb
`define TZFE_COL_EMPTY 12'hCCB
`define TZFE_COL_GAP 12'hBBA
`define TZFE_COL_PANEL 12'hFEC
`define TZFE_COL_INK 12'h776

`endif
